//--- hdl/tcb_mon_pkg.sv
// shared widths and packed types for the bus-transfer monitor
// imported by the control, FIFO and top level
// record layout: request, then response, then cycle counters

`default_nettype none

package tcb_mon_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // field widths
    ////////////////////////////////////////////////////////////////////////////

    // address and data bus widths
    localparam int unsigned ADR_W = 16;
    localparam int unsigned DAT_W = 32;

    // idle / back-pressure counters, saturating
    localparam int unsigned CNT_W = 8;

    ////////////////////////////////////////////////////////////////////////////
    // record parts
    ////////////////////////////////////////////////////////////////////////////

    // request channel, sampled on the transfer cycle
    typedef struct packed {
        logic             wen;
        logic [ADR_W-1:0] adr;
        logic [DAT_W-1:0] wdt;
    } req_t;

    // response channel, sampled DLY cycles later
    typedef struct packed {
        logic [DAT_W-1:0] rdt;
        logic             err;
    } rsp_t;

    // cycles spent before the transfer
    typedef struct packed {
        logic [CNT_W-1:0] idl;
        logic [CNT_W-1:0] bpr;
    } cnt_t;

    // one FIFO entry per transfer
    typedef struct packed {
        req_t req;
        rsp_t rsp;
        cnt_t cnt;
    } rec_t;

endpackage : tcb_mon_pkg

`default_nettype wire

//--- hdl/tcb_mon_dly.sv
// generic payload delay line, DLY register stages
// used for the request fields and for the captured counters
// first stage takes din on en, zero otherwise

`default_nettype none

module tcb_mon_dly #(
    // number of stages, at least 1
    parameter int unsigned DLY = 2,
    // payload type, any packed type
    parameter type         T   = logic
)(
    // clock and reset
    input  wire   mon,
    input  wire   arst_n,
    // load strobe and payload
    input  wire   en,
    input  wire T din,
    // payload after DLY cycles
    output T      dout
);

    ////////////////////////////////////////////////////////////////////////////
    // stages
    ////////////////////////////////////////////////////////////////////////////

    // stg[0] is the newest entry
    T stg [DLY];

    // shifts on every edge, no hold
    always_ff @(posedge mon or negedge arst_n) begin
        if (!arst_n) begin
            for (int unsigned i = 0; i < DLY; i++) begin
                stg[i] <= T'('0);
            end
        end else begin
            // empty slot when no transfer
            if (en) begin
                stg[0] <= din;
            end else begin
                stg[0] <= T'('0);
            end
            // move everything one step on
            for (int unsigned i = 1; i < DLY; i++) begin
                stg[i] <= stg[i-1];
            end
        end
    end

    // oldest stage
    assign dout = stg[DLY-1];

endmodule : tcb_mon_dly

`default_nettype wire

//--- hdl/tcb_mon_ctl.sv
// monitor control: transfer detection, idle and back-pressure counting,
// transfer strobe delay and FIFO write / overflow decision
// the bus is only observed, never driven or stalled

`default_nettype none

module tcb_mon_ctl
    import tcb_mon_pkg::*;
#(
    // response delay in cycles, at least 1
    parameter int unsigned DLY = 2
)(
    // clock and reset
    input  wire         mon,
    input  wire         arst_n,
    // bus handshake
    input  wire         bus_vld,
    input  wire         bus_rdy,
    // FIFO state and host pop
    input  wire         full,
    input  wire         rd,
    // transfer strobe and current counts
    output logic        trn,
    output cnt_t        cnt,
    // FIFO write and sticky overflow
    output logic        wr,
    output logic        ovf
);

    ////////////////////////////////////////////////////////////////////////////
    // transfer and cycle classification
    ////////////////////////////////////////////////////////////////////////////

    // delayed transfer strobe, last stage lines up with the response
    logic [DLY-1:0] trn_dly;

    // idle: nothing offered, slave ready
    logic           cyc_idl;
    // back-pressure: request offered, slave not ready
    logic           cyc_bpr;

    assign trn     =  bus_vld &  bus_rdy;
    assign cyc_idl = ~bus_vld &  bus_rdy;
    assign cyc_bpr =  bus_vld & ~bus_rdy;

    ////////////////////////////////////////////////////////////////////////////
    // saturating counters
    ////////////////////////////////////////////////////////////////////////////

    // counts go out with trn, then restart at zero
    always_ff @(posedge mon or negedge arst_n) begin
        if (!arst_n) begin
            cnt.idl <= '0;
            cnt.bpr <= '0;
        end else if (trn) begin
            cnt.idl <= '0;
            cnt.bpr <= '0;
        end else begin
            // stop at all ones
            if (cyc_idl && (cnt.idl != '1)) begin
                cnt.idl <= cnt.idl + 1'b1;
            end
            if (cyc_bpr && (cnt.bpr != '1)) begin
                cnt.bpr <= cnt.bpr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // strobe delay, write and overflow
    ////////////////////////////////////////////////////////////////////////////

    // DLY-deep shift, same depth as the payload delay lines
    always_ff @(posedge mon or negedge arst_n) begin
        if (!arst_n) begin
            trn_dly <= '0;
        end else begin
            trn_dly[0] <= trn;
            for (int unsigned i = 1; i < DLY; i++) begin
                trn_dly[i] <= trn_dly[i-1];
            end
        end
    end

    // a pop on the same edge frees a slot, so full alone does not block
    assign wr = trn_dly[DLY-1] & (~full | rd);

    // record lost, flag stays set until reset
    always_ff @(posedge mon or negedge arst_n) begin
        if (!arst_n) begin
            ovf <= 1'b0;
        end else if (trn_dly[DLY-1] && full && !rd) begin
            ovf <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // bus protocol check
    ////////////////////////////////////////////////////////////////////////////

    // an offered request may not be withdrawn while stalled
    a_vld_hold: assert property (
        @(posedge mon) disable iff (!arst_n)
        (bus_vld && !bus_rdy) |=> bus_vld
    );

endmodule : tcb_mon_ctl

`default_nettype wire

//--- hdl/tcb_mon_fifo.sv
// record FIFO between the monitor and the host
// first-word fall-through: dout shows the oldest record while vld is high
// simultaneous write and read are allowed, also when full

`default_nettype none

module tcb_mon_fifo
    import tcb_mon_pkg::*;
#(
    // number of entries, power of two
    parameter int unsigned DEPTH = 8
)(
    // clock and reset
    input  wire        mon,
    input  wire        arst_n,
    // write side
    input  wire        wr,
    input  wire rec_t  din,
    // read side
    input  wire        rd,
    output rec_t       dout,
    // state
    output logic       vld,
    output logic       full
);

    ////////////////////////////////////////////////////////////////////////////
    // storage and pointers
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned AW = $clog2(DEPTH);

    // occupancy value when every slot is used
    localparam logic [AW:0] CNT_FULL = (AW+1)'(DEPTH);

    // record memory
    rec_t mem [DEPTH];

    // pointers wrap naturally, DEPTH is a power of two
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;

    // occupancy, one bit wider than the pointers
    logic [AW:0]   cnt;

    ////////////////////////////////////////////////////////////////////////////
    // write
    ////////////////////////////////////////////////////////////////////////////

    // when full and read together, wr_ptr == rd_ptr and the slot is freed
    always_ff @(posedge mon) begin
        if (wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge mon or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
        end else if (wr) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge mon or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
        end else if (rd) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // both together leave the count unchanged
    always_ff @(posedge mon or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else begin
            case ({wr, rd})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

    assign dout = mem[rd_ptr];
    assign vld  = (cnt != '0);
    assign full = (cnt == CNT_FULL);

    ////////////////////////////////////////////////////////////////////////////
    // checks on the control and host side
    ////////////////////////////////////////////////////////////////////////////

    // control must drop a record instead of overwriting
    a_no_wr_full: assert property (
        @(posedge mon) disable iff (!arst_n)
        (wr && full) |-> rd
    );

    // host pop only counts while a record is shown
    a_no_rd_empty: assert property (
        @(posedge mon) disable iff (!arst_n)
        rd |-> vld
    );

endmodule : tcb_mon_fifo

`default_nettype wire

//--- hdl/tcb_mon_top.sv
// passive bus-transfer monitor, top level
// one record per transfer: request, delayed response, idle and
// back-pressure counts; records are drained through rec_rd pops
// DLY must match the bus response delay

`default_nettype none

module tcb_mon_top
    import tcb_mon_pkg::*;
#(
    parameter int unsigned DLY   = 2,
    parameter int unsigned DEPTH = 8
)(
    // clock and reset
    input  wire              mon,
    input  wire              arst_n,
    // bus handshake
    input  wire              bus_vld,
    input  wire              bus_rdy,
    // bus request
    input  wire              bus_wen,
    input  wire [ADR_W-1:0]  bus_adr,
    input  wire [DAT_W-1:0]  bus_wdt,
    // bus response, DLY cycles after the transfer
    input  wire [DAT_W-1:0]  bus_rdt,
    input  wire              bus_err,
    // host pop
    input  wire              rec_rd,
    // oldest record
    output logic             rec_vld,
    output logic             rec_wen,
    output logic [ADR_W-1:0] rec_adr,
    output logic [DAT_W-1:0] rec_wdt,
    output logic [DAT_W-1:0] rec_rdt,
    output logic             rec_err,
    output logic [CNT_W-1:0] rec_idl,
    output logic [CNT_W-1:0] rec_bpr,
    // records were lost
    output logic             ovf
);

    // control and FIFO handshake
    logic trn;
    logic wr;
    logic full;
    logic pop;

    // payloads before and after the delay lines
    req_t bus_req;
    req_t req_dly;
    cnt_t cnt_now;
    cnt_t cnt_dly;

    // FIFO in and out
    rec_t rec_in;
    rec_t rec_out;

    ////////////////////////////////////////////////////////////////////////////
    // control and delay lines
    ////////////////////////////////////////////////////////////////////////////

    // a pop only while a record is shown
    assign pop = rec_rd & rec_vld;

    tcb_mon_ctl #(
        .DLY (DLY)
    ) u_ctl (
        .mon     (mon),
        .arst_n  (arst_n),
        .bus_vld (bus_vld),
        .bus_rdy (bus_rdy),
        .full    (full),
        .rd      (pop),
        .trn     (trn),
        .cnt     (cnt_now),
        .wr      (wr),
        .ovf     (ovf)
    );

    assign bus_req = '{wen: bus_wen, adr: bus_adr, wdt: bus_wdt};

    // request fields follow the transfer strobe
    tcb_mon_dly #(
        .DLY (DLY),
        .T   (req_t)
    ) d_req (
        .mon    (mon),
        .arst_n (arst_n),
        .en     (trn),
        .din    (bus_req),
        .dout   (req_dly)
    );

    // counts captured on the transfer cycle
    tcb_mon_dly #(
        .DLY (DLY),
        .T   (cnt_t)
    ) d_cnt (
        .mon    (mon),
        .arst_n (arst_n),
        .en     (trn),
        .din    (cnt_now),
        .dout   (cnt_dly)
    );

    ////////////////////////////////////////////////////////////////////////////
    // record FIFO
    ////////////////////////////////////////////////////////////////////////////

    // delayed request and counts meet the live response here
    assign rec_in = '{req: req_dly, rsp: '{rdt: bus_rdt, err: bus_err}, cnt: cnt_dly};

    tcb_mon_fifo #(
        .DEPTH (DEPTH)
    ) u_fifo (
        .mon    (mon),
        .arst_n (arst_n),
        .wr     (wr),
        .din    (rec_in),
        .rd     (pop),
        .dout   (rec_out),
        .vld    (rec_vld),
        .full   (full)
    );

    // record fields to the host
    assign rec_wen = rec_out.req.wen;
    assign rec_adr = rec_out.req.adr;
    assign rec_wdt = rec_out.req.wdt;
    assign rec_rdt = rec_out.rsp.rdt;
    assign rec_err = rec_out.rsp.err;
    assign rec_idl = rec_out.cnt.idl;
    assign rec_bpr = rec_out.cnt.bpr;

endmodule : tcb_mon_top

`default_nettype wire

//--- verif/tcb_mon_tb.sv
// testbench for the bus-transfer monitor
// replays verif/tcb_mon_tests.txt on the bus, supplies the delayed
// responses and drains the record FIFO with random host stalls
// each record is compared with one built from the counting rule

`default_nettype none

module tcb_mon_tb
    import tcb_mon_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DLY   = 2;
    localparam int DEPTH = 8;
    // counters stop here
    localparam int CNT_MAX     = (1 << CNT_W) - 1;
    // cycles allowed for the FIFO to empty
    localparam int DRAIN_LIMIT = 2000;

    logic             mon;
    logic             arst_n;
    logic             bus_vld;
    logic             bus_rdy;
    logic             bus_wen;
    logic [ADR_W-1:0] bus_adr;
    logic [DAT_W-1:0] bus_wdt;
    logic [DAT_W-1:0] bus_rdt;
    logic             bus_err;
    logic             rec_rd;
    logic             rec_vld;
    logic             rec_wen;
    logic [ADR_W-1:0] rec_adr;
    logic [DAT_W-1:0] rec_wdt;
    logic [DAT_W-1:0] rec_rdt;
    logic             rec_err;
    logic [CNT_W-1:0] rec_idl;
    logic [CNT_W-1:0] rec_bpr;
    logic             ovf;

    // responses waiting to go out, oldest first
    rsp_t rsp_pipe [$];
    // records still to be seen, in transfer order
    rec_t exp_q [$];

    logic host_hold = 1'b0;
    logic exp_ovf   = 1'b0;
    int   held_n    = 0;
    int   n_checked = 0;
    int   seed      = 43020;

    tcb_mon_top #(
        .DLY   (DLY),
        .DEPTH (DEPTH)
    ) uut (
        .mon     (mon),
        .arst_n  (arst_n),
        .bus_vld (bus_vld),
        .bus_rdy (bus_rdy),
        .bus_wen (bus_wen),
        .bus_adr (bus_adr),
        .bus_wdt (bus_wdt),
        .bus_rdt (bus_rdt),
        .bus_err (bus_err),
        .rec_rd  (rec_rd),
        .rec_vld (rec_vld),
        .rec_wen (rec_wen),
        .rec_adr (rec_adr),
        .rec_wdt (rec_wdt),
        .rec_rdt (rec_rdt),
        .rec_err (rec_err),
        .rec_idl (rec_idl),
        .rec_bpr (rec_bpr),
        .ovf     (ovf)
    );

    initial begin
        mon = 1'b0;
        forever #5 mon = ~mon;
    end

    ////////////////////////////////////////////////////////////////////////////
    // failure reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_error(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
        stop_on_failure();
    endtask

    task automatic fail_in_words(input string what);
        $display("%s", what);
        stop_on_failure();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // bus side
    ////////////////////////////////////////////////////////////////////////////

    // run length as the monitor reports it
    function automatic logic [CNT_W-1:0] sat_count(input int n);
        if (n > CNT_MAX) begin
            return '1;
        end
        return n[CNT_W-1:0];
    endfunction

    // one bus cycle; the response queued DLY cycles ago goes out now
    task automatic drive_cycle(input logic vld, input logic rdy, input req_t req,
                               input rsp_t rsp);
        rsp_t rsp_out;
        @(posedge mon);
        rsp_out = rsp_pipe.pop_front();
        bus_vld <= vld;
        bus_rdy <= rdy;
        bus_wen <= req.wen;
        bus_adr <= req.adr;
        bus_wdt <= req.wdt;
        bus_rdt <= rsp_out.rdt;
        bus_err <= rsp_out.err;
        // response buses stay zero unless a transfer is answered
        if (vld && rdy) begin
            rsp_pipe.push_back(rsp);
        end else begin
            rsp_pipe.push_back('0);
        end
    endtask

    // dead cycles until every expected record has been read
    task automatic wait_drain(input string what);
        int n;
        n = 0;
        @(negedge mon);
        while (exp_q.size() != 0 || rec_vld) begin
            if (n == DRAIN_LIMIT) begin
                fail_in_words({"timeout while waiting for the ", what});
            end
            drive_cycle(1'b0, 1'b0, '0, '0);
            @(negedge mon);
            n++;
        end
    endtask

    // let the last held records land, then free the host
    task automatic release_hold();
        repeat (DLY + 1) begin
            drive_cycle(1'b0, 1'b0, '0, '0);
        end
        @(negedge mon);
        assert (ovf == exp_ovf) else value_error("ovf", 64'(ovf), 64'(exp_ovf));
        assert (rec_vld == 1'b1) else value_error("rec_vld", 64'(rec_vld), 64'(1));
        host_hold = 1'b0;
    endtask

    // idle, dead and back-pressure cycles, then the transfer itself
    task automatic run_transfer(input int hold_f, input int n_idle, input int n_dead,
                                input int n_bpr, input req_t req, input rsp_t rsp);
        rec_t e;
        if (hold_f != 0 && !host_hold) begin
            // start the held stretch from an empty FIFO
            wait_drain("FIFO to drain before the host is held off");
            assert (ovf == exp_ovf) else value_error("ovf", 64'(ovf), 64'(exp_ovf));
            host_hold = 1'b1;
            held_n = 0;
        end else if (hold_f == 0 && host_hold) begin
            release_hold();
        end
        repeat (n_idle) begin
            drive_cycle(1'b0, 1'b1, '0, '0);
        end
        repeat (n_dead) begin
            drive_cycle(1'b0, 1'b0, '0, '0);
        end
        // request held stable while stalled
        repeat (n_bpr) begin
            drive_cycle(1'b1, 1'b0, req, '0);
        end
        drive_cycle(1'b1, 1'b1, req, rsp);
        e.req     = req;
        e.rsp     = rsp;
        e.cnt.idl = sat_count(n_idle);
        e.cnt.bpr = sat_count(n_bpr);
        // a full FIFO with no pop loses the record
        if (!host_hold || held_n < DEPTH) begin
            exp_q.push_back(e);
        end else begin
            exp_ovf = 1'b1;
        end
        if (host_hold) begin
            held_n++;
        end
    endtask

    initial begin : driver
        int          fd;
        int          code;
        string       line;
        int          hold_v;
        int          idle_v;
        int          dead_v;
        int          bpr_v;
        logic [31:0] wen_v;
        logic [31:0] adr_v;
        logic [31:0] wdt_v;
        logic [31:0] rdt_v;
        logic [31:0] err_v;
        req_t        req;
        rsp_t        rsp;
        arst_n  = 1'b0;
        bus_vld = 1'b0;
        bus_rdy = 1'b0;
        bus_wen = 1'b0;
        bus_adr = '0;
        bus_wdt = '0;
        bus_rdt = '0;
        bus_err = 1'b0;
        repeat (DLY) begin
            rsp_pipe.push_back('0);
        end
        fd = $fopen("verif/tcb_mon_tests.txt", "r");
        if (fd == 0) begin
            fail_in_words("cannot open the test data file");
        end
        repeat (5) @(posedge mon);
        arst_n <= 1'b1;
        @(negedge mon);
        assert (rec_vld == 1'b0) else value_error("rec_vld", 64'(rec_vld), 64'(0));
        assert (ovf == 1'b0) else value_error("ovf", 64'(ovf), 64'(0));
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            // comments and blank lines carry no transfer
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                code = $sscanf(line, "%d %d %d %d %h %h %h %h %h", hold_v, idle_v, dead_v,
                               bpr_v, wen_v, adr_v, wdt_v, rdt_v, err_v);
                if (code != 9) begin
                    fail_in_words("malformed line in the test data file");
                end
                req.wen = wen_v[0];
                req.adr = adr_v[ADR_W-1:0];
                req.wdt = wdt_v[DAT_W-1:0];
                rsp.rdt = rdt_v[DAT_W-1:0];
                rsp.err = err_v[0];
                run_transfer(hold_v, idle_v, dead_v, bpr_v, req, rsp);
            end
        end
        $fclose(fd);
        if (host_hold) begin
            release_hold();
        end
        wait_drain("last records to be read");
        // overflow is sticky
        assert (ovf == exp_ovf) else value_error("ovf", 64'(ovf), 64'(exp_ovf));
        $display("checked %0d records", n_checked);
        $display("TEST OK");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // host side
    ////////////////////////////////////////////////////////////////////////////

    // the shown record leaves at the next edge
    task automatic check_record();
        rec_t e;
        if (exp_q.size() == 0) begin
            fail_in_words("a record was shown that belongs to no transfer");
        end
        e = exp_q.pop_front();
        assert (rec_wen == e.req.wen) else value_error("rec_wen", 64'(rec_wen), 64'(e.req.wen));
        assert (rec_adr == e.req.adr) else value_error("rec_adr", 64'(rec_adr), 64'(e.req.adr));
        assert (rec_wdt == e.req.wdt) else value_error("rec_wdt", 64'(rec_wdt), 64'(e.req.wdt));
        assert (rec_rdt == e.rsp.rdt) else value_error("rec_rdt", 64'(rec_rdt), 64'(e.rsp.rdt));
        assert (rec_err == e.rsp.err) else value_error("rec_err", 64'(rec_err), 64'(e.rsp.err));
        assert (rec_idl == e.cnt.idl) else value_error("rec_idl", 64'(rec_idl), 64'(e.cnt.idl));
        assert (rec_bpr == e.cnt.bpr) else value_error("rec_bpr", 64'(rec_bpr), 64'(e.cnt.bpr));
        n_checked++;
    endtask

    // pops on about three cycles in four, none while held
    initial begin : reader
        logic [31:0] r;
        rec_rd = 1'b0;
        forever begin
            @(posedge mon);
            r = $random(seed);
            rec_rd <= !host_hold && (r[1:0] != 2'b00);
            @(negedge mon);
            if (rec_rd && rec_vld) begin
                check_record();
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tcb_mon_tests.txt
# columns: hold idle dead bpr wen adr wdt rdt err
# hold and the three cycle counts are decimal, the other fields hex
# first transfers after reset, counts start from zero
0 3 0 0 1 0100 11112222 00000000 0
0 0 0 0 0 0104 00000000 a5a5a5a5 0
0 0 2 0 1 0108 deadbeef 00000000 1
0 2 3 1 0 010c 00000000 12345678 0
0 0 4 0 1 0110 cafef00d 00000000 0
0 0 0 5 0 0114 00000000 87654321 1
0 1 1 1 1 0118 0badf00d 00000000 0
0 4 2 3 0 011c 00000000 0f0f0f0f 0
# long runs stop at 255
0 300 0 0 0 0200 00000000 55aa55aa 0
0 0 2 270 1 0204 feedface 00000000 0
0 255 0 0 0 0208 00000000 aa55aa55 1
0 0 0 254 1 020c 01234567 00000000 0
0 256 9 256 0 0210 00000000 76543210 0
# back-to-back transfers
0 20 0 0 1 0300 a0000001 00000000 0
0 0 0 0 1 0304 a0000002 00000000 0
0 0 0 0 0 0308 00000000 b0000003 0
0 0 0 0 0 030c 00000000 b0000004 1
0 0 0 0 1 0310 a0000005 00000000 0
# host held off, the last three of eleven records are lost
1 2 0 0 1 0400 c0000000 00000000 0
1 0 0 0 0 0404 00000000 c1111111 0
1 0 1 0 1 0408 c2222222 00000000 1
1 1 0 2 0 040c 00000000 c3333333 0
1 0 0 0 1 0410 c4444444 00000000 0
1 3 0 0 0 0414 00000000 c5555555 0
1 0 0 1 1 0418 c6666666 00000000 0
1 0 0 0 0 041c 00000000 c7777777 1
1 0 0 0 1 0420 c8888888 00000000 0
1 5 0 0 0 0424 00000000 c9999999 0
1 0 0 0 1 0428 caaaaaaa 00000000 0
# normal traffic once the FIFO is drained
0 6 0 0 0 0500 00000000 d0000000 0
0 0 0 0 1 0504 d1111111 00000000 0
0 0 0 3 0 0508 00000000 d2222222 1
0 1 2 0 1 050c d3333333 00000000 0
0 0 0 0 0 0510 00000000 d4444444 0
0 7 1 7 1 0514 d5555555 00000000 1
0 0 0 0 0 0518 00000000 d6666666 0
0 2 0 0 1 051c d7777777 00000000 0

//--- files.f
hdl/tcb_mon_pkg.sv
hdl/tcb_mon_dly.sv
hdl/tcb_mon_ctl.sv
hdl/tcb_mon_fifo.sv
hdl/tcb_mon_top.sv
verif/tcb_mon_tb.sv

//--- run.sh
#!/bin/sh
# build the monitor testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tcb_mon_tb -f files.f || exit 1
out="$(./obj_dir/Vtcb_mon_tb 2>&1)"
echo "$out"
echo "$out" | grep -qx "TEST OK" && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}
